// File: flist.f
scroll_pkg.sv
layer_sequencer.sv
tile_fetch.sv
pixel_writer.sv
line_buffer.sv
scroll_top.sv
scroll_sva.sv
tb_scroll.sv

// File: Makefile
# Verilator build and run of the scroll renderer testbench

VERILATOR ?= verilator
TOP       ?= tb_scroll
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= all tests passed

SOURCES := $(shell cat $(FLIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_scroll.sv
/*
 * Testbench for the scroll renderer. VRAM and ROM models answer with
 * random latency, random lines are rendered (some aborted midway) and
 * every hdump position of the three layers is checked against a model.
 */
module tb_scroll import scroll_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int lines      = 20;
    localparam int line_limit = 60000;   // cycles allowed per line

    logic        clk, rst;
    logic [8:0]  vrender, hdump;
    logic        preVB, start;
    logic [15:0] vram1_base, vram2_base, vram3_base;
    logic [15:0] hpos1, hpos2, hpos3;
    logic [15:0] vpos1, vpos2, vpos3;
    logic [2:0]  gfx_en;
    logic [16:0] vram_addr;
    logic        vram_cs, vram_ok;
    logic [15:0] vram_data;
    logic [19:0] rom_addr;
    logic        rom_cs, rom_ok;
    logic [31:0] rom_data;
    logic [8:0]  scr1_pxl, scr2_pxl, scr3_pxl;
    logic        line_done;

    logic [15:0] vram [0:(1 << 17) - 1];
    logic [31:0] rom [0:(1 << 20) - 1];
    logic [8:0]  expected [0:2][0:screen_width - 1];
    integer      seed = 32'hbb4b_2c81;
    int          pixel_errors = 0;
    int          done_errors = 0;
    int          assert_errors = 0;
    int          cycles = 0;

    scroll_top scroll_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == lines * line_limit) begin
            $display("Timeout after %0d cycles, a render or sweep never finished", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // Answers each request after 0 to 3 idle cycles
    task automatic serve_vram();
        int wait_cycles;
        vram_ok = 1'b0;
        vram_data = '0;
        wait_cycles = -1;
        forever begin
            @(negedge clk);
            if (vram_ok) begin
                vram_ok = 1'b0;
                wait_cycles = -1;
            end else if (vram_cs) begin
                if (wait_cycles < 0)
                    wait_cycles = {$random(seed)} % 4;
                if (wait_cycles == 0) begin
                    vram_ok = 1'b1;
                    vram_data = vram[vram_addr];
                end else
                    wait_cycles--;
            end
        end
    endtask

    task automatic serve_rom();
        int wait_cycles;
        rom_ok = 1'b0;
        rom_data = '0;
        wait_cycles = -1;
        forever begin
            @(negedge clk);
            if (rom_ok) begin
                rom_ok = 1'b0;
                wait_cycles = -1;
            end else if (rom_cs) begin
                if (wait_cycles < 0)
                    wait_cycles = {$random(seed)} % 4;
                if (wait_cycles == 0) begin
                    rom_ok = 1'b1;
                    rom_data = rom[rom_addr];
                end else
                    wait_cycles--;
            end
        end
    endtask

    task automatic fill_memories();
        for (int a = 0; a < (1 << 17); a++)
            vram[a] = 16'($random(seed));   // attr bits 5 and 6 give random flips
        for (int a = 0; a < (1 << 20); a++)
            rom[a] = $random(seed);
    endtask

    task automatic randomize_line(int n);
        vram1_base = 16'($random(seed));
        vram2_base = 16'($random(seed));
        vram3_base = 16'($random(seed));
        hpos1 = 16'($random(seed));
        hpos2 = 16'($random(seed));
        hpos3 = 16'($random(seed));
        vpos1 = 16'($random(seed));
        vpos2 = 16'($random(seed));
        vpos3 = 16'($random(seed));
        vrender = 9'($random(seed));
        gfx_en = n % 4 == 3 ? 3'($random(seed)) : 3'b111;
    endtask

    // Expected line for all layers, straight from the addressing rules
    task automatic build_expected();
        int s, segs, ys, r, addr, src, pos, hp, vp, base;
        logic [15:0] code, attr;
        logic [31:0] word;
        logic [3:0]  color;
        for (int l = 0; l < 3; l++) begin
            s = 8 << l;
            segs = s / 8;
            hp = l == 0 ? hpos1 : (l == 1 ? hpos2 : hpos3);
            vp = l == 0 ? vpos1 : (l == 1 ? vpos2 : vpos3);
            base = l == 0 ? vram1_base : (l == 1 ? vram2_base : vram3_base);
            ys = (vrender + vp) % 65536;
            for (int x = 0; x < screen_width; x++)
                expected[l][x] = blank_pixel;
            for (int t = 0; t < active_pixels / s + 1; t++) begin
                addr = (base * 2 + 2 * ((ys / s) % 64 * 64 + (hp / s + t) % 64)) % (1 << 17);
                code = vram[addr];
                attr = vram[(addr + 1) % (1 << 17)];
                r = attr[6] ? s - 1 - ys % s : ys % s;
                for (int g = 0; g < segs; g++) begin
                    src = attr[5] ? segs - 1 - g : g;
                    word = rom[(code * (s * s / 8) + r * segs + src) % (1 << 20)];
                    for (int n = 0; n < 8; n++) begin
                        color = word[4 * (attr[5] ? 7 - n : n) +: 4];
                        pos = active_start - hp % s + t * s + g * 8 + n;
                        if (pos >= active_start && pos <= active_end)
                            expected[l][pos] = color == 4'hf ? blank_pixel : {attr[4:0], color};
                    end
                end
            end
        end
    endtask

    task automatic check_pixel(layer_t l, int h, logic [8:0] got, logic [8:0] want);
        if (got !== want) begin
            pixel_errors++;
            $display("ERROR scr%0d_pxl at hdump %0d: got %h, expected %h",
                     int'(l) + 1, h, got, want);
        end
    endtask

    task automatic check_done(string name, logic got, logic want);
        if (got !== want) begin
            done_errors++;
            $display("ERROR %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_line_done();
        @(negedge clk);
        while (!line_done)
            @(negedge clk);
        @(negedge clk);
        check_done("line_done", line_done, 1'b0);   // one cycle pulse
    endtask

    // Pixel for hdump k shows up two clocks later
    task automatic sweep_compare();
        logic [8:0] want;
        logic [8:0] got [0:2];
        for (int k = 0; k < screen_width + 2; k++) begin
            @(negedge clk);
            if (k >= 2) begin
                got = '{scr1_pxl, scr2_pxl, scr3_pxl};
                for (int l = 0; l < 3; l++) begin
                    want = blank_pixel;
                    if (gfx_en[l] && k - 2 >= active_start && k - 2 <= active_end)
                        want = expected[l][k - 2];
                    check_pixel(layer_t'(l), k - 2, got[l], want);
                end
            end
            if (k < screen_width)
                hdump = 9'(k);
        end
    endtask

    initial begin
        int count;
        fork
            serve_vram();
            serve_rom();
        join_none
        rst = 1'b1;
        start = 1'b0;
        preVB = 1'b0;
        hdump = '0;
        randomize_line(0);
        fill_memories();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_pixel(layer_1, 0, scr1_pxl, blank_pixel);
        check_pixel(layer_2, 0, scr2_pxl, blank_pixel);
        check_pixel(layer_3, 0, scr3_pxl, blank_pixel);
        check_done("vram_cs", vram_cs, 1'b0);
        check_done("rom_cs", rom_cs, 1'b0);
        check_done("line_done", line_done, 1'b0);
        for (int n = 0; n < lines; n++) begin
            randomize_line(n);
            pulse_start();
            if (n % 3 == 1) begin
                repeat (20 + {$random(seed)} % 400) @(negedge clk);
                pulse_start();      // restarts the same line
            end
            wait_line_done();
            build_expected();
            pulse_start();          // swap, finished line goes to readout
            sweep_compare();
            if (n == 5) begin
                // Later layers of the background render pick up new registers
                randomize_line(n);
                wait_line_done();
                preVB = 1'b1;
                pulse_start();
                count = 0;
                repeat (6000) begin
                    @(negedge clk);
                    if (line_done)
                        count++;
                end
                check_done("line_done", count != 0, 1'b0);
                preVB = 1'b0;
                sweep_compare();    // same half still on readout
            end
        end
        assert_errors = scroll_top_inst.scroll_sva_inst.failures;
        $display("pixel errors: %0d, control errors: %0d, assertion errors: %0d",
                 pixel_errors, done_errors, assert_errors);
        if (pixel_errors + done_errors + assert_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: scroll_sva.sv
/*
 * Assertions bound into scroll_top. VRAM and ROM requests hold until
 * ok, reads only start while a line is queued or rendering, and hdump
 * outside the active area gives blank pixels two clocks later.
 */
module scroll_sva_chk import scroll_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         vram_cs,
    input logic         vram_ok,
    input logic [16:0]  vram_addr,
    input logic         rom_cs,
    input logic         rom_ok,
    input logic [19:0]  rom_addr,
    input logic         seq_busy,
    input logic         seq_req,
    input logic [8:0]   hdump,
    input logic [8:0]   scr1_pxl,
    input logic [8:0]   scr2_pxl,
    input logic [8:0]   scr3_pxl
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    vram_hold: assert property (@(posedge clk) disable iff (rst)
        vram_cs && !vram_ok |=> vram_cs && $stable(vram_addr))
        else begin
            failures++;
            $error("VRAM request dropped or address moved before ok");
        end

    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            failures++;
            $error("ROM request dropped or address moved before ok");
        end

    // No bus traffic while the renderer is idle
    vram_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(vram_cs) |-> $past(seq_busy || seq_req))
        else begin
            failures++;
            $error("VRAM read started with no line queued or rendering");
        end

    rom_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(rom_cs) |-> $past(seq_busy || seq_req))
        else begin
            failures++;
            $error("ROM read started with no line queued or rendering");
        end

    blank_outside: assert property (@(posedge clk) disable iff (rst)
        (hdump < 9'(active_start) || hdump > 9'(active_end)) |-> ##2
            (scr1_pxl == blank_pixel && scr2_pxl == blank_pixel && scr3_pxl == blank_pixel))
        else begin
            failures++;
            $error("Pixel shown outside the active area");
        end

endmodule

bind scroll_top scroll_sva_chk scroll_sva_inst (
    .clk(clk), .rst(rst), .vram_cs(vram_cs), .vram_ok(vram_ok), .vram_addr(vram_addr),
    .rom_cs(rom_cs), .rom_ok(rom_ok), .rom_addr(rom_addr),
    .seq_busy(layer_sequencer_inst.busy), .seq_req(layer_sequencer_inst.req),
    .hdump(hdump),
    .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl), .scr3_pxl(scr3_pxl)
);

// File: scroll_top.sv
/*
 * Scroll renderer top level. Sequencer, tile fetch and pixel writer
 * share the VRAM and ROM buses and fill three per-layer line buffers.
 */
module scroll_top import scroll_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [8:0]  vrender,
    input  logic [8:0]  hdump,
    input  logic        preVB,
    input  logic [15:0] vram1_base,
    input  logic [15:0] vram2_base,
    input  logic [15:0] vram3_base,
    input  logic [15:0] hpos1,
    input  logic [15:0] hpos2,
    input  logic [15:0] hpos3,
    input  logic [15:0] vpos1,
    input  logic [15:0] vpos2,
    input  logic [15:0] vpos3,
    input  logic [2:0]  gfx_en,
    input  logic        start,
    output logic [16:0] vram_addr,
    output logic        vram_cs,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    output logic [19:0] rom_addr,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output logic [8:0]  scr1_pxl,
    output logic [8:0]  scr2_pxl,
    output logic [8:0]  scr3_pxl,
    output logic        line_done
);

    layer_t             layer;
    logic               layer_start, abort, layer_done;
    logic [15:0]        hpos, vpos, vram_base;
    logic               rd_half, wr_half;
    logic               writer_busy, tile_valid, last_tile;
    logic [15:0]        tile_code, tile_attr;
    logic signed [10:0] tile_x;
    logic               buf_wr;
    logic [8:0]         buf_addr, buf_data;

    layer_sequencer layer_sequencer_inst (.*);

    tile_fetch tile_fetch_inst (.*);

    pixel_writer pixel_writer_inst (.*, .busy(writer_busy));

    // The active layer owns the write port
    line_buffer line1_inst (
        .clk(clk), .rst(rst), .wr(buf_wr && layer == layer_1), .wr_half(wr_half),
        .wr_addr(buf_addr), .wr_data(buf_data), .rd_half(rd_half), .hdump(hdump),
        .enable(gfx_en[0]), .pxl(scr1_pxl)
    );

    line_buffer line2_inst (
        .clk(clk), .rst(rst), .wr(buf_wr && layer == layer_2), .wr_half(wr_half),
        .wr_addr(buf_addr), .wr_data(buf_data), .rd_half(rd_half), .hdump(hdump),
        .enable(gfx_en[1]), .pxl(scr2_pxl)
    );

    line_buffer line3_inst (
        .clk(clk), .rst(rst), .wr(buf_wr && layer == layer_3), .wr_half(wr_half),
        .wr_addr(buf_addr), .wr_data(buf_data), .rd_half(rd_half), .hdump(hdump),
        .enable(gfx_en[2]), .pxl(scr3_pxl)
    );

endmodule

// File: line_buffer.sv
/*
 * Ping-pong line memory for one layer. One half is written by the
 * renderer while the other is read out by hdump, two clocks of
 * latency, blanked outside the active area or when disabled.
 */
module line_buffer import scroll_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr,
    input  logic       wr_half,
    input  logic [8:0] wr_addr,
    input  logic [8:0] wr_data,
    input  logic       rd_half,
    input  logic [8:0] hdump,
    input  logic       enable,
    output logic [8:0] pxl
);

    logic [8:0] mem [0:2*screen_width-1];
    logic [8:0] rd_q;
    logic       show_q;     // visibility, aligned with rd_q

    always_ff @(posedge clk) begin
        if (wr)
            mem[{wr_half, wr_addr}] <= wr_data;
        rd_q <= mem[{rd_half, hdump}];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            show_q <= 1'b0;
            pxl    <= blank_pixel;
        end else begin
            show_q <= enable && hdump >= active_start && hdump <= active_end;
            pxl    <= show_q ? rd_q : blank_pixel;
        end
    end

endmodule

// File: pixel_writer.sv
/*
 * Tile row decoder. For each tile from the fetch stage it reads the
 * ROM words of the needed row, applies the flips and writes eight
 * 4-bit pixels per word into the line buffer, one per clock.
 */
module pixel_writer import scroll_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  layer_t             layer,
    input  logic               abort,
    input  logic [8:0]         vrender,
    input  logic [15:0]        vpos,
    input  logic               tile_valid,
    input  logic [15:0]        tile_code,
    input  logic [15:0]        tile_attr,
    input  logic signed [10:0] tile_x,
    input  logic               last_tile,
    input  logic [31:0]        rom_data,
    input  logic               rom_ok,
    output logic [19:0]        rom_addr,
    output logic               rom_cs,
    output logic               busy,
    output logic               layer_done,
    output logic               buf_wr,
    output logic [8:0]         buf_addr,
    output logic [8:0]         buf_data
);

    typedef enum logic [1:0] {wr_idle, wr_rom, wr_pix} wr_state_t;

    wr_state_t          state;
    logic [15:0]        code;
    logic [4:0]         pal;
    logic               hflip;
    logic               vflip;
    logic               last;
    logic signed [10:0] base_x;
    logic [1:0]         seg;        // 8-pixel segment within the tile row
    logic [2:0]         nib;
    logic [31:0]        word;
    logic [15:0]        ys;
    logic [3:0]         color;
    logic signed [10:0] pos;
    int unsigned        size;
    int unsigned        segs;
    int unsigned        row;
    int unsigned        src_seg;
    int unsigned        src_nib;

    always_comb begin
        size    = tile_size(layer);
        segs    = size / 8;
        ys      = {7'd0, vrender} + vpos;
        row     = ys % size;
        if (vflip)
            row = size - 1 - row;
        src_seg = hflip ? segs - 1 - seg : seg;
        src_nib = hflip ? 7 - nib : nib;
        color   = word[4*src_nib +: 4];
        pos     = base_x + 11'({seg, 3'b000}) + 11'(nib);
    end

    // Held off while a dropped read still waits for its ok
    assign busy = state != wr_idle || rom_cs;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= wr_idle;
            rom_cs     <= 1'b0;
            buf_wr     <= 1'b0;
            layer_done <= 1'b0;
        end else begin
            buf_wr     <= 1'b0;
            layer_done <= 1'b0;
            if (rom_cs && rom_ok)
                rom_cs <= 1'b0;
            case (state)
                wr_idle: if (tile_valid) begin
                    code   <= tile_code;
                    pal    <= tile_attr[4:0];
                    hflip  <= tile_attr[5];
                    vflip  <= tile_attr[6];
                    base_x <= tile_x;
                    last   <= last_tile;
                    seg    <= 2'd0;
                    state  <= wr_rom;
                end
                wr_rom: begin
                    if (!rom_cs) begin
                        rom_cs   <= 1'b1;
                        rom_addr <= 20'(32'(code) * (size * size / 8) + row * segs + src_seg);
                    end else if (rom_ok) begin
                        word  <= rom_data;
                        nib   <= 3'd0;
                        state <= wr_pix;
                    end
                end
                default: begin
                    buf_wr   <= pos >= active_start && pos <= active_end;
                    buf_addr <= pos[8:0];
                    buf_data <= color == transparent_color ? blank_pixel : {pal, color};
                    nib      <= nib + 3'd1;
                    if (nib == 3'd7) begin
                        if (32'(seg) == segs - 1) begin
                            layer_done <= last;     // end of the pass
                            state      <= wr_idle;
                        end else begin
                            seg   <= seg + 2'd1;
                            state <= wr_rom;
                        end
                    end
                end
            endcase
            if (abort) begin
                state      <= wr_idle;
                buf_wr     <= 1'b0;
                layer_done <= 1'b0;
            end
        end
    end

endmodule

// File: tile_fetch.sv
/*
 * Tilemap reader for one layer pass. Finds the map row and first column
 * for the current line, reads the code and attribute word of each tile
 * from VRAM and hands the tiles one by one to the pixel writer.
 */
module tile_fetch import scroll_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  layer_t             layer,
    input  logic               layer_start,
    input  logic               abort,
    input  logic [8:0]         vrender,
    input  logic [15:0]        hpos,
    input  logic [15:0]        vpos,
    input  logic [15:0]        vram_base,
    input  logic               writer_busy,
    input  logic [15:0]        vram_data,
    input  logic               vram_ok,
    output logic [16:0]        vram_addr,
    output logic               vram_cs,
    output logic               tile_valid,
    output logic [15:0]        tile_code,
    output logic [15:0]        tile_attr,
    output logic signed [10:0] tile_x,
    output logic               last_tile
);

    fetch_state_t       state;
    logic               pend;       // start seen while a read drains
    logic [5:0]         row;
    logic [5:0]         col;
    logic [5:0]         count;
    logic signed [10:0] next_x;
    logic [15:0]        ys;
    logic [16:0]        code_addr;
    int unsigned        size;
    int unsigned        ntiles;

    always_comb begin
        size   = tile_size(layer);
        ntiles = active_pixels / size + 1;   // one extra for partial tiles
        ys     = {7'd0, vrender} + vpos;
    end

    // Two words per map entry, wraps at 17 bits
    assign code_addr = {vram_base, 1'b0} + {4'd0, row, col, 1'b0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= fetch_idle;
            pend       <= 1'b0;
            vram_cs    <= 1'b0;
            tile_valid <= 1'b0;
            last_tile  <= 1'b0;
        end else begin
            tile_valid <= 1'b0;
            if (vram_cs && vram_ok)
                vram_cs <= 1'b0;
            case (state)
                fetch_idle: begin
                    if (layer_start)
                        pend <= 1'b1;
                    if ((layer_start || pend) && !vram_cs) begin
                        pend   <= 1'b0;
                        row    <= 6'((ys / size) % map_tiles);
                        col    <= 6'((hpos / size) % map_tiles);
                        next_x <= 11'(active_start) - 11'(hpos % size);
                        count  <= 6'd0;
                        state  <= fetch_code;
                    end
                end
                fetch_code: begin
                    if (!vram_cs) begin
                        vram_cs   <= 1'b1;
                        vram_addr <= code_addr;
                    end else if (vram_ok) begin
                        tile_code <= vram_data;
                        state     <= fetch_attr;
                    end
                end
                fetch_attr: begin
                    if (!vram_cs) begin
                        vram_cs   <= 1'b1;
                        vram_addr <= code_addr + 17'd1;
                    end else if (vram_ok) begin
                        tile_attr <= vram_data;
                        state     <= fetch_hand;
                    end
                end
                fetch_hand: begin
                    if (!writer_busy) begin
                        tile_valid <= 1'b1;
                        tile_x     <= next_x;
                        last_tile  <= 32'(count) == ntiles - 1;
                        next_x     <= next_x + 11'(size);
                        col        <= col + 6'd1;   // map wraps around
                        count      <= count + 6'd1;
                        state      <= 32'(count) == ntiles - 1 ? fetch_done : fetch_code;
                    end
                end
                default: state <= fetch_idle;
            endcase
            if (abort) begin
                state      <= fetch_idle;
                pend       <= 1'b0;
                tile_valid <= 1'b0;
            end
        end
    end

endmodule

// File: layer_sequencer.sv
/*
 * Render sequencer. Accepts start edges outside pre-vblank, swaps the
 * line buffer halves and runs one pass per layer, loading that layer's
 * scroll registers and VRAM base before each pass.
 */
module layer_sequencer import scroll_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        preVB,
    input  logic [15:0] vram1_base,
    input  logic [15:0] vram2_base,
    input  logic [15:0] vram3_base,
    input  logic [15:0] hpos1,
    input  logic [15:0] hpos2,
    input  logic [15:0] hpos3,
    input  logic [15:0] vpos1,
    input  logic [15:0] vpos2,
    input  logic [15:0] vpos3,
    input  logic        layer_done,
    output layer_t      layer,
    output logic        layer_start,
    output logic        abort,
    output logic [15:0] hpos,
    output logic [15:0] vpos,
    output logic [15:0] vram_base,
    output logic        rd_half,
    output logic        wr_half,
    output logic        line_done
);

    logic last_start;
    logic req;          // render queued
    logic busy;
    logic accept;

    assign accept = start && !last_start && !preVB;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_start  <= 1'b0;
            req         <= 1'b0;
            busy        <= 1'b0;
            layer       <= layer_1;
            layer_start <= 1'b0;
            abort       <= 1'b0;
            line_done   <= 1'b0;
            rd_half     <= 1'b0;
            wr_half     <= 1'b1;
        end else begin
            last_start  <= start;
            layer_start <= 1'b0;
            abort       <= 1'b0;
            line_done   <= 1'b0;
            if (req && !busy) begin
                req         <= 1'b0;
                busy        <= 1'b1;
                wr_half     <= ~wr_half;
                layer       <= layer_1;
                layer_start <= 1'b1;
                hpos        <= hpos1;
                vpos        <= vpos1;
                vram_base   <= vram1_base;
            end else if (busy && layer_done) begin
                case (layer)
                    layer_1: begin
                        layer       <= layer_2;
                        layer_start <= 1'b1;
                        hpos        <= hpos2;
                        vpos        <= vpos2;
                        vram_base   <= vram2_base;
                    end
                    layer_2: begin
                        layer       <= layer_3;
                        layer_start <= 1'b1;
                        hpos        <= hpos3;
                        vpos        <= vpos3;
                        vram_base   <= vram3_base;
                    end
                    default: begin
                        busy      <= 1'b0;     // whole line rendered
                        line_done <= 1'b1;
                    end
                endcase
            end
            // A new line cancels whatever is still running
            if (accept) begin
                req         <= 1'b1;
                rd_half     <= ~rd_half;
                abort       <= 1'b1;
                busy        <= 1'b0;
                layer_start <= 1'b0;
            end
        end
    end

endmodule

// File: scroll_pkg.sv
/*
 * Shared types and constants for the three-layer scroll renderer.
 * Holds the layer and fetch-state enums, the screen geometry and the
 * per-layer tile size. Modules pull it in with a wildcard import.
 */
package scroll_pkg;

    // Layer being rendered, one pass per layer
    typedef enum logic [1:0] {
        layer_1,
        layer_2,
        layer_3
    } layer_t;

    // tile_fetch FSM
    typedef enum logic [2:0] {
        fetch_idle,
        fetch_code,   // tilemap code word
        fetch_attr,   // tilemap attribute word
        fetch_hand,   // waiting to hand the tile over
        fetch_done
    } fetch_state_t;

    localparam int screen_width  = 512;   // hdump range, one buffer half
    localparam int active_start  = 64;
    localparam int active_end    = 447;
    localparam int active_pixels = 384;
    localparam int map_tiles     = 64;    // tiles per map row and column

    localparam logic [8:0] blank_pixel       = 9'h1ff;
    localparam logic [3:0] transparent_color = 4'hf;

    // Tile edge in pixels for each layer
    function automatic int unsigned tile_size(layer_t l);
        case (l)
            layer_1: return 8;
            layer_2: return 16;
            default: return 32;
        endcase
    endfunction

endpackage
